/* design/rename_defs.svh */
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// Architectural sizes of the rename slice

// RV32I integer register file
`define ARCH_REGS 32

// Physical register file behind the rename tables
`define PHYS_REGS 64

// Free physical registers, at most PHYS_REGS minus the nonzero
// architectural mappings and the pinned x0
`define FREE_DEPTH 32

// In-order rename log, one entry per allocation
`define LOG_DEPTH 32

`endif

/* design/rename_pkg.sv */
`include "rename_defs.svh"

package rename_pkg;

    typedef logic [$clog2(`ARCH_REGS)-1:0] areg_t;  // Architectural index
    typedef logic [$clog2(`PHYS_REGS)-1:0] preg_t;  // Physical index

    // RV32I major opcodes handled by the renamer
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_t;

    // One allocation, kept until retire
    typedef struct packed {
        areg_t rd;
        preg_t new_pd;
        preg_t old_pd;  // Mapping displaced by this instruction
    } log_entry_t;

endpackage

/* design/rename_decode.sv */
`timescale 1ns/1ps

module rename_decode
    import rename_pkg::*;
(
    input  logic [31:0] instr,
    output areg_t       rs1,
    output areg_t       rs2,
    output areg_t       rd,
    output logic        uses_rs1,
    output logic        uses_rs2,
    output logic        writes_rd
);

    opcode_t opcode;

    assign opcode = opcode_t'(instr[6:0]);

    always_comb begin
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        writes_rd = 1'b0;
        case (opcode)
            op_lui, op_auipc, op_jal: begin
                writes_rd = 1'b1;  // Immediate or PC only
            end
            op_jalr, op_load, op_imm: begin
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
            end
            op_reg: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                writes_rd = 1'b1;
            end
            op_branch, op_store: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;  // No destination
            end
            default: begin
                // FENCE, SYSTEM and unknown opcodes touch no register
            end
        endcase
    end

    // Fields that the opcode does not use read as x0
    assign rs1 = uses_rs1  ? instr[19:15] : '0;
    assign rs2 = uses_rs2  ? instr[24:20] : '0;
    assign rd  = writes_rd ? instr[11:7]  : '0;

endmodule

/* design/free_list.sv */
`timescale 1ns/1ps
`include "rename_defs.svh"

module free_list
    import rename_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       alloc,
    input  logic       release_en,
    input  logic       commit,
    input  logic       flush,
    input  preg_t      release_preg,
    output preg_t      free_preg,
    output logic       free_empty,
    output logic [5:0] free_count
);

    localparam int AW = $clog2(`FREE_DEPTH);

    preg_t       entries [`FREE_DEPTH];
    logic [AW:0] head;         // Next slot for a released register
    logic [AW:0] tail;         // Oldest free register, speculative
    logic [AW:0] tail_commit;  // Tail as seen by retired instructions

    // Top bit of each pointer tells a full queue from an empty one
    assign free_preg  = entries[tail[AW-1:0]];
    assign free_empty = (head == tail);
    assign free_count = 6'(head - tail);

    always_ff @(posedge clk) begin
        if (rst) begin
            head        <= {1'b1, {AW{1'b0}}};  // All slots hold a free register
            tail        <= '0;
            tail_commit <= '0;
        end else begin
            if (release_en) begin
                head <= head + 1'b1;
            end
            if (commit) begin
                tail_commit <= tail_commit + 1'b1;  // One retired allocation
            end
            if (flush) begin
                tail <= tail_commit;  // Speculative allocations become free again
            end else if (alloc) begin
                tail <= tail + 1'b1;
            end
        end
    end

    // Registers above the architectural ones start out free, in order
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `FREE_DEPTH; i++) begin
                entries[i] <= preg_t'(`ARCH_REGS + i);
            end
        end else if (release_en) begin
            entries[head[AW-1:0]] <= release_preg;
        end
    end

endmodule

/* design/rename_map.sv */
`timescale 1ns/1ps
`include "rename_defs.svh"

module rename_map
    import rename_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       instr_valid,
    input  logic       flush,
    input  areg_t      rs1,
    input  areg_t      rs2,
    input  areg_t      rd,
    input  logic       uses_rs1,
    input  logic       uses_rs2,
    input  logic       writes_rd,
    input  preg_t      free_preg,
    input  logic       free_empty,
    input  logic       log_full,
    input  preg_t      committed_table [`ARCH_REGS],
    output logic       alloc,
    output logic       log_push,
    output log_entry_t log_entry,
    output logic       rename_valid,
    output logic       stall,
    output preg_t      ps1,
    output preg_t      ps2,
    output preg_t      pd,
    output preg_t      old_pd
);

    preg_t spec_table [`ARCH_REGS];
    logic  need_alloc;
    logic  blocked;
    logic  accept;

    assign need_alloc = writes_rd && (rd != '0);  // x0 stays on physical 0
    assign blocked    = need_alloc && (free_empty || log_full);
    assign accept     = instr_valid && !flush && !blocked;
    assign alloc      = accept && need_alloc;
    assign log_push   = alloc;
    assign log_entry  = '{rd: rd, new_pd: free_preg, old_pd: spec_table[rd]};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                spec_table[i] <= preg_t'(i);  // Identity mapping
            end
        end else if (flush) begin
            spec_table <= committed_table;
        end else if (alloc) begin
            spec_table[rd] <= free_preg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rename_valid <= 1'b0;
            stall        <= 1'b0;
        end else begin
            rename_valid <= accept;
            stall        <= instr_valid && !flush && blocked;  // Instruction is dropped
        end
    end

    // Sources see the table before this instruction's own write
    always_ff @(posedge clk) begin
        ps1    <= uses_rs1 ? spec_table[rs1] : '0;
        ps2    <= uses_rs2 ? spec_table[rs2] : '0;
        pd     <= alloc ? free_preg : '0;
        old_pd <= need_alloc ? spec_table[rd] : '0;
    end

endmodule

/* design/retire_unit.sv */
`timescale 1ns/1ps
`include "rename_defs.svh"

module retire_unit
    import rename_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       retire,
    input  logic       flush,
    input  logic       log_push,
    input  log_entry_t log_entry,
    output logic       log_full,
    output logic       release_en,
    output logic       commit,
    output preg_t      release_preg,
    output preg_t      committed_table [`ARCH_REGS]
);

    localparam int AW = $clog2(`LOG_DEPTH);

    log_entry_t  log_mem [`LOG_DEPTH];
    log_entry_t  oldest;
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        log_empty;

    assign oldest    = log_mem[rd_ptr[AW-1:0]];
    assign log_empty = (wr_ptr == rd_ptr);
    assign log_full  = (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]) && (wr_ptr[AW] != rd_ptr[AW]);

    // Retire on an empty log, or under flush, does nothing
    assign commit       = retire && !flush && !log_empty;
    assign release_en   = commit;
    assign release_preg = oldest.old_pd;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= rd_ptr;  // Drop every speculative entry
        end else begin
            if (log_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (commit) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (log_push) begin
            log_mem[wr_ptr[AW-1:0]] <= log_entry;
        end
    end

    // Architectural state as of the last retired instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                committed_table[i] <= preg_t'(i);
            end
        end else if (commit) begin
            committed_table[oldest.rd] <= oldest.new_pd;
        end
    end

endmodule

/* design/rename_top.sv */
`timescale 1ns/1ps
`include "rename_defs.svh"

module rename_top
    import rename_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic        retire,
    input  logic        flush,
    output logic        rename_valid,
    output preg_t       ps1,
    output preg_t       ps2,
    output preg_t       pd,
    output preg_t       old_pd,
    output logic        stall,
    output logic [5:0]  free_count
);

    areg_t      rs1;
    areg_t      rs2;
    areg_t      rd;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       writes_rd;
    logic       alloc;
    logic       log_push;
    log_entry_t log_entry;
    logic       free_empty;
    logic       log_full;
    logic       release_en;
    logic       commit;
    preg_t      release_preg;
    preg_t      free_preg;
    preg_t      committed_table [`ARCH_REGS];

    rename_decode u_decode (
        .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd),
        .uses_rs1(uses_rs1), .uses_rs2(uses_rs2), .writes_rd(writes_rd)
    );

    rename_map u_map (
        .clk(clk), .rst(rst), .instr_valid(instr_valid), .flush(flush),
        .rs1(rs1), .rs2(rs2), .rd(rd),
        .uses_rs1(uses_rs1), .uses_rs2(uses_rs2), .writes_rd(writes_rd),
        .free_preg(free_preg), .free_empty(free_empty), .log_full(log_full),
        .committed_table(committed_table),
        .alloc(alloc), .log_push(log_push), .log_entry(log_entry),
        .rename_valid(rename_valid), .stall(stall),
        .ps1(ps1), .ps2(ps2), .pd(pd), .old_pd(old_pd)
    );

    free_list u_free_list (
        .clk(clk), .rst(rst), .alloc(alloc), .release_en(release_en),
        .commit(commit), .flush(flush), .release_preg(release_preg),
        .free_preg(free_preg), .free_empty(free_empty), .free_count(free_count)
    );

    retire_unit u_retire (
        .clk(clk), .rst(rst), .retire(retire), .flush(flush),
        .log_push(log_push), .log_entry(log_entry), .log_full(log_full),
        .release_en(release_en), .commit(commit), .release_preg(release_preg),
        .committed_table(committed_table)
    );

endmodule

/* testbench/rename_tb.sv */
`timescale 1ns/1ps
`include "rename_defs.svh"

module rename_tb
    import rename_pkg::*;
();

    localparam int clk_period      = 20;
    localparam int directed_cycles = 120;
    localparam int random_cycles   = 400;
    localparam int watchdog_ns     = 2 * (4 + directed_cycles + random_cycles) * clk_period;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic        retire;
    logic        flush;
    logic        rename_valid;
    logic        stall;
    preg_t       ps1, ps2, pd, old_pd;
    logic [5:0]  free_count;

    // Reference model state and the response it predicts
    preg_t       spec_map [`ARCH_REGS];
    preg_t       commit_map [`ARCH_REGS];
    preg_t       free_q [$];
    log_entry_t  log_q [$];
    logic        exp_rv, exp_stall;
    preg_t       exp_ps1, exp_ps2, exp_pd, exp_old;
    logic [5:0]  exp_count;
    logic        obs_rv, obs_stall;  // DUT outputs seen at the last compare
    preg_t       obs_ps1, obs_ps2, obs_pd, obs_old;
    logic [5:0]  obs_count;
    int          errors, checks, tests;

    rename_top uut (
        .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr),
        .retire(retire), .flush(flush), .rename_valid(rename_valid),
        .ps1(ps1), .ps2(ps2), .pd(pd), .old_pd(old_pd), .stall(stall),
        .free_count(free_count)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
        $display("Result: FAILED");
        $finish;
    end

    task automatic check_preg(input string name, input preg_t got, input preg_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
        end
    endtask

    task automatic check_count(input string name, input logic [5:0] got, input logic [5:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
        end
    endtask

    function automatic logic [31:0] encode(opcode_t op, areg_t rd, areg_t rs1, areg_t rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, op};
    endfunction

    // Register use from the RV32I formats of each opcode
    function automatic void decode_fields(input logic [31:0] ins, output areg_t s1,
                                          output areg_t s2, output areg_t d,
                                          output logic u1, output logic u2, output logic w);
        logic [6:0] op;
        logic       known;
        op    = ins[6:0];
        known = op inside {op_lui, op_auipc, op_jal, op_jalr, op_branch, op_load,
                           op_store, op_imm, op_reg};
        w     = known && !(op inside {op_branch, op_store});      // B and S formats have no rd
        u1    = known && !(op inside {op_lui, op_auipc, op_jal});  // U and J formats have no rs1
        u2    = op inside {op_reg, op_branch, op_store};          // R, S and B formats read rs2
        s1    = u1 ? ins[19:15] : '0;
        s2    = u2 ? ins[24:20] : '0;
        d     = w ? ins[11:7] : '0;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < `ARCH_REGS; i++) begin
            spec_map[i]   = preg_t'(i);
            commit_map[i] = preg_t'(i);
            free_q.push_back(preg_t'(`ARCH_REGS + i));  // Upper half starts free
        end
        exp_rv    = 1'b0;
        exp_stall = 1'b0;
        exp_count = 6'd32;
    endtask

    task automatic model_step(input logic v, input logic [31:0] ins, input logic ret,
                              input logic fl);
        areg_t      s1, s2, d;
        logic       u1, u2, w, need, blocked, do_commit;
        log_entry_t e;
        exp_rv    = 1'b0;
        exp_stall = 1'b0;
        if (fl) begin
            spec_map = commit_map;
            for (int i = log_q.size() - 1; i >= 0; i--) begin
                free_q.push_front(log_q[i].new_pd);  // Discarded allocations go back in order
            end
            log_q.delete();
        end else begin
            decode_fields(ins, s1, s2, d, u1, u2, w);
            need      = w && (d != 5'd0);
            blocked   = need && (free_q.size() == 0 || log_q.size() == `LOG_DEPTH);
            do_commit = ret && (log_q.size() > 0);  // Log state before this edge
            exp_stall = v && blocked;
            if (v && !blocked) begin
                exp_rv  = 1'b1;
                exp_ps1 = u1 ? spec_map[s1] : '0;
                exp_ps2 = u2 ? spec_map[s2] : '0;
                exp_old = need ? spec_map[d] : '0;
                exp_pd  = '0;
                if (need) begin
                    exp_pd = free_q.pop_front();
                    e = '{rd: d, new_pd: exp_pd, old_pd: exp_old};
                    log_q.push_back(e);
                    spec_map[d] = exp_pd;
                end
            end
            if (do_commit) begin
                e = log_q.pop_front();
                commit_map[e.rd] = e.new_pd;
                free_q.push_back(e.old_pd);
            end
        end
        exp_count = 6'(free_q.size());
    endtask

    task automatic compare_outputs();
        check_flag("rename_valid", rename_valid, exp_rv);
        check_flag("stall", stall, exp_stall);
        if (exp_rv) begin
            check_preg("ps1", ps1, exp_ps1);
            check_preg("ps2", ps2, exp_ps2);
            check_preg("pd", pd, exp_pd);
            check_preg("old_pd", old_pd, exp_old);
        end
        check_count("free_count", free_count, exp_count);
        {obs_rv, obs_stall, obs_count} = {rename_valid, stall, free_count};
        {obs_ps1, obs_ps2, obs_pd, obs_old} = {ps1, ps2, pd, old_pd};
    endtask

    // Starts at a rising edge and checks the response to the previous step
    task automatic step(input logic v, input logic [31:0] ins, input logic ret, input logic fl);
        instr_valid <= v;
        instr       <= ins;
        retire      <= ret;
        flush       <= fl;
        @(negedge clk);
        compare_outputs();
        model_step(v, ins, ret, fl);
        @(posedge clk);
    endtask

    task automatic idle_cycle();
        step(1'b0, 32'h0, 1'b0, 1'b0);
    endtask

    task automatic rename_one(input logic [31:0] ins);
        step(1'b1, ins, 1'b0, 1'b0);
        idle_cycle();
    endtask

    task automatic report_test(input string name, input int err_start);
        tests++;
        $display("test %s finished with %0d errors", name, errors - err_start);
    endtask

    task automatic test_first_rename();
        int err_start;
        err_start = errors;
        step(1'b1, encode(op_reg, 5'd1, 5'd2, 5'd3), 1'b0, 1'b0);
        check_count("free_count", obs_count, 6'd32);
        idle_cycle();
        check_flag("rename_valid", obs_rv, 1'b1);
        check_preg("ps1", obs_ps1, 6'd2);
        check_preg("ps2", obs_ps2, 6'd3);
        check_preg("pd", obs_pd, 6'd32);
        check_preg("old_pd", obs_old, 6'd1);
        report_test("first rename", err_start);
    endtask

    task automatic test_dependencies();
        int err_start;
        err_start = errors;
        rename_one(encode(op_reg, 5'd4, 5'd1, 5'd0));  // Reads the new x1 and x0
        check_preg("ps1", obs_ps1, 6'd32);
        check_preg("ps2", obs_ps2, 6'd0);
        check_preg("pd", obs_pd, 6'd33);
        rename_one(encode(op_imm, 5'd0, 5'd4, 5'd0));
        check_preg("pd", obs_pd, 6'd0);
        check_count("free_count", obs_count, 6'd30);
        rename_one(encode(op_store, 5'd8, 5'd1, 5'd4));
        check_flag("rename_valid", obs_rv, 1'b1);
        check_preg("ps2", obs_ps2, 6'd33);
        check_count("free_count", obs_count, 6'd30);
        report_test("dependencies", err_start);
    endtask

    task automatic test_exhaust();
        int err_start;
        err_start = errors;
        step(1'b0, 32'h0, 1'b0, 1'b1);
        for (int i = 0; i < 32; i++) begin
            step(1'b1, encode(op_imm, areg_t'(i % 31 + 1), 5'd0, 5'd0), 1'b0, 1'b0);
        end
        idle_cycle();
        check_count("free_count", obs_count, 6'd0);
        rename_one(encode(op_imm, 5'd7, 5'd2, 5'd0));
        check_flag("stall", obs_stall, 1'b1);
        check_flag("rename_valid", obs_rv, 1'b0);
        rename_one(encode(op_store, 5'd0, 5'd3, 5'd4));  // Store renames its sources only
        check_flag("rename_valid", obs_rv, 1'b1);
        report_test("free list exhaustion", err_start);
    endtask

    task automatic test_retire_order();
        int    err_start;
        preg_t released [$];
        err_start = errors;
        for (int i = 0; i < 4; i++) begin
            released.push_back(log_q[i].old_pd);
        end
        for (int i = 0; i < 4; i++) begin
            step(1'b0, 32'h0, 1'b1, 1'b0);
            idle_cycle();
            check_count("free_count", obs_count, 6'(i + 1));
        end
        for (int i = 0; i < 4; i++) begin
            rename_one(encode(op_lui, areg_t'(10 + i), 5'd0, 5'd0));
            check_preg("pd", obs_pd, released[i]);
        end
        report_test("retire order", err_start);
    endtask

    task automatic test_flush_recovery();
        int    err_start;
        preg_t first_discarded, want_ps1, want_ps2, want_old;
        err_start       = errors;
        first_discarded = log_q[0].new_pd;
        step(1'b0, 32'h0, 1'b0, 1'b1);
        idle_cycle();
        check_count("free_count", obs_count, 6'd32);
        step(1'b0, 32'h0, 1'b1, 1'b0);  // Log is empty now
        idle_cycle();
        check_count("free_count", obs_count, 6'd32);
        want_ps1 = commit_map[1];
        want_ps2 = commit_map[2];
        want_old = commit_map[5];
        rename_one(encode(op_reg, 5'd5, 5'd1, 5'd2));
        check_preg("ps1", obs_ps1, want_ps1);
        check_preg("ps2", obs_ps2, want_ps2);
        check_preg("pd", obs_pd, first_discarded);
        check_preg("old_pd", obs_old, want_old);
        report_test("flush recovery", err_start);
    endtask

    function automatic logic [31:0] random_instr();
        logic [31:0] ins;
        ins = $urandom();
        case ($urandom_range(9, 0))
            0: ins[6:0] = op_lui;
            1: ins[6:0] = op_auipc;
            2: ins[6:0] = op_jal;
            3: ins[6:0] = op_jalr;
            4: ins[6:0] = op_branch;
            5: ins[6:0] = op_load;
            6: ins[6:0] = op_store;
            7: ins[6:0] = op_imm;
            8: ins[6:0] = op_reg;
            default: ins[6:0] = 7'b0001111;  // FENCE
        endcase
        return ins;
    endfunction

    task automatic test_random();
        int          err_start;
        logic [31:0] ins;
        err_start = errors;
        for (int i = 0; i < random_cycles; i++) begin
            ins = random_instr();
            step($urandom_range(3, 0) != 0, ins, $urandom_range(2, 0) == 0,
                 $urandom_range(23, 0) == 0);
        end
        idle_cycle();
        report_test("random mix", err_start);
    endtask

    initial begin
        void'($urandom(32'hce4a));
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = 32'h0;
        retire      = 1'b0;
        flush       = 1'b0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        model_reset();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        test_first_rename();
        test_dependencies();
        test_exhaust();
        test_retire_order();
        test_flush_recovery();
        test_random();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* rename_top.f */
+incdir+design
design/rename_pkg.sv
design/rename_decode.sv
design/free_list.sv
design/rename_map.sv
design/retire_unit.sv
design/rename_top.sv
testbench/rename_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := rename_tb
FILELIST := rename_top.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) design/rename_defs.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
